// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_video_fader
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
src/fader_pkg.sv
src/axil_regs.sv
src/block_locator.sv
src/fade_sequencer.sv
src/smoother.sv
src/video_fader_top.sv
tests/video_fader_checker.sv
tests/tb_video_fader.sv

// ==== src/axil_regs.sv ====
module axil_regs (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic [fader_pkg::AXI_AW-1:0]      awaddr_i,
   input  logic                              awvalid_i,
   output logic                              awready_o,
   input  logic [fader_pkg::AXI_DW-1:0]      wdata_i,
   input  logic [fader_pkg::AXI_DW/8-1:0]    wstrb_i,
   input  logic                              wvalid_i,
   output logic                              wready_o,
   output logic [1:0]                        bresp_o,
   output logic                              bvalid_o,
   input  logic                              bready_i,
   input  logic [fader_pkg::AXI_AW-1:0]      araddr_i,
   input  logic                              arvalid_i,
   output logic                              arready_o,
   output logic [fader_pkg::AXI_DW-1:0]      rdata_o,
   output logic [1:0]                        rresp_o,
   output logic                              rvalid_o,
   input  logic                              rready_i,
   input  logic [3:0]                        status_i,
   output logic                              dark_req_o,
   output logic                              light_req_o,
   output logic                              pat_inv_o
);

   logic                         wr_go;
   logic                         rd_go;
   logic                         dark_q;
   logic                         light_q;
   logic                         pat_q;
   logic [fader_pkg::AXI_DW-1:0] rd_word;

   // address and data taken together, held off while a response is pending
   assign wr_go     = awvalid_i & wvalid_i & ~bvalid_o;
   assign awready_o = wr_go;
   assign wready_o  = wr_go;
   assign rd_go     = arvalid_i & ~rvalid_o;
   assign arready_o = ~rvalid_o;
   assign bresp_o   = 2'b00; // always okay
   assign rresp_o   = 2'b00;

   always_comb begin
      rd_word = '0;
      case (araddr_i)
         fader_pkg::REG_CTRL: begin
            rd_word[fader_pkg::CTRL_DARK]  = dark_q;
            rd_word[fader_pkg::CTRL_LIGHT] = light_q;
         end
         fader_pkg::REG_PATTERN: rd_word[fader_pkg::PAT_INV] = pat_q;
         fader_pkg::REG_STATUS:  rd_word[3:0] = status_i; // live status
         default: ;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
         dark_q   <= 1'b0;
         light_q  <= 1'b0;
         pat_q    <= 1'b0;
      end else begin
         if (wr_go) begin
            bvalid_o <= 1'b1;
         end else if (bready_i) begin
            bvalid_o <= 1'b0;
         end
         if (rd_go) begin
            rvalid_o <= 1'b1;
         end else if (rready_i) begin
            rvalid_o <= 1'b0;
         end
         if (wr_go && wstrb_i[0]) begin
            if (awaddr_i == fader_pkg::REG_CTRL) begin
               dark_q  <= wdata_i[fader_pkg::CTRL_DARK];
               light_q <= wdata_i[fader_pkg::CTRL_LIGHT];
            end else if (awaddr_i == fader_pkg::REG_PATTERN) begin
               pat_q <= wdata_i[fader_pkg::PAT_INV];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_go) begin
         rdata_o <= rd_word; // held until next accepted read
      end
   end

   assign dark_req_o  = dark_q;
   assign light_req_o = light_q;
   assign pat_inv_o   = pat_q;

endmodule

// ==== src/block_locator.sv ====
module block_locator #(
   parameter int HBLKS = 10,
   parameter int VBLKS = 10,
   parameter int BLK_W = 64,
   parameter int BLK_H = 64
) (
   input  logic                             clk_i,
   input  logic                             rst_ni,
   input  logic                             vin_vs_i,
   input  logic                             vin_hs_i,
   input  logic                             vin_de_i,
   input  logic [fader_pkg::PIX_W-1:0]      vin_data_i,
   input  logic                             pat_inv_i,
   output logic                             vs_o,
   output logic                             hs_o,
   output logic                             de_o,
   output logic [fader_pkg::PIX_W-1:0]      data_o,
   output logic [$clog2(HBLKS)-1:0]         ht_cur_o,
   output logic [$clog2(VBLKS)-1:0]         vt_cur_o,
   output logic                             blk_o
);

   localparam int SX_W = $clog2(BLK_W + 1);
   localparam int SY_W = $clog2(BLK_H + 1);
   localparam int HT_W = $clog2(HBLKS);
   localparam int VT_W = $clog2(VBLKS);

   logic [SX_W-1:0] sub_x;
   logic [SY_W-1:0] sub_y;
   logic [HT_W-1:0] ht;
   logic [VT_W-1:0] vt;
   logic            de_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         {vs_o, hs_o, de_o, de_q, blk_o} <= '0;
         {sub_x, sub_y, ht, vt} <= '0;
         ht_cur_o <= '0;
         vt_cur_o <= '0;
      end else begin
         vs_o     <= vin_vs_i;
         hs_o     <= vin_hs_i;
         de_o     <= vin_de_i;
         de_q     <= vin_de_i;
         ht_cur_o <= ht; // coordinates of the current pixel
         vt_cur_o <= vt;
         blk_o    <= ht[0] ^ vt[0] ^ pat_inv_i;
         if (vin_vs_i) begin // new frame
            {sub_x, sub_y, ht, vt} <= '0;
         end else if (vin_de_i) begin
            sub_x <= (sub_x == SX_W'(BLK_W - 1)) ? '0 : sub_x + 1'b1;
            if (sub_x == SX_W'(BLK_W - 1)) begin
               ht <= (ht == HT_W'(HBLKS - 1)) ? '0 : ht + 1'b1;
            end
         end else if (de_q) begin // end of active line
            sub_x <= '0;
            ht    <= '0;
            sub_y <= (sub_y == SY_W'(BLK_H - 1)) ? '0 : sub_y + 1'b1;
            if (sub_y == SY_W'(BLK_H - 1)) begin
               vt <= (vt == VT_W'(VBLKS - 1)) ? '0 : vt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      data_o <= vin_data_i;
   end

endmodule

// ==== src/fade_sequencer.sv ====
module fade_sequencer #(
   parameter int SW_DELAY  = 16,
   parameter int PHASE     = 2048,
   parameter int PHASE_DIV = 1
) (
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  logic                       req_i,
   output logic                       en_o,
   output logic                       wipe_o,
   output logic [$clog2(PHASE)-1:0]   phase_o
);

   localparam int DLY_W = $clog2(SW_DELAY + 1);
   localparam int DIV_W = $clog2(PHASE_DIV + 1);

   logic [DLY_W-1:0] dly_cnt;
   logic [DIV_W-1:0] div_cnt;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         en_o    <= 1'b0;
         wipe_o  <= 1'b0;
         phase_o <= '0;
         dly_cnt <= '0;
         div_cnt <= '0;
      end else begin
         if (wipe_o) begin
            if (div_cnt < DIV_W'(PHASE_DIV - 1)) begin
               div_cnt <= div_cnt + 1'b1;
            end else if (phase_o < $bits(phase_o)'(PHASE - 1)) begin
               phase_o <= phase_o + 1'b1;
               div_cnt <= '0;
            end else begin // sweep done
               wipe_o  <= 1'b0;
               phase_o <= '0;
               div_cnt <= '0;
            end
         end
         if (req_i == en_o) begin
            dly_cnt <= '0; // request withdrawn
         end else if (dly_cnt < DLY_W'(SW_DELAY - 1)) begin
            dly_cnt <= dly_cnt + 1'b1;
         end else begin
            en_o    <= req_i;
            dly_cnt <= '0;
            phase_o <= '0;
            div_cnt <= '0;
            wipe_o  <= ~wipe_o; // running wipe is dropped, new state at once
         end
      end
   end

endmodule

// ==== src/fader_pkg.sv ====
package fader_pkg;

   localparam int PIX_W  = 24; // rgb888
   localparam int COMP_W = 8;
   localparam int AXI_AW = 4;
   localparam int AXI_DW = 32;
   localparam int PHX_W  = 8; // blend phase
   localparam int FAN_W  = 5; // log2 of front width

   // control register
   localparam logic [AXI_AW-1:0] REG_CTRL = 4'h0;
   localparam int CTRL_DARK  = 0;
   localparam int CTRL_LIGHT = 1;

   // pattern register
   localparam logic [AXI_AW-1:0] REG_PATTERN = 4'h4;
   localparam int PAT_INV = 0; // swap checkerboard parity

   // status register, read only
   localparam logic [AXI_AW-1:0] REG_STATUS = 4'h8;
   localparam int ST_DARK_EN    = 0;
   localparam int ST_LIGHT_EN   = 1;
   localparam int ST_DARK_WIPE  = 2;
   localparam int ST_LIGHT_WIPE = 3;

endpackage

// ==== src/smoother.sv ====
module smoother #(
   parameter int HBLKS     = 10,
   parameter int VBLKS     = 10,
   parameter int SW_DELAY  = 16,
   parameter int PHASE_DIV = 1
) (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           dl_i,
   input  logic                           ld_i,
   input  logic                           vin_vs_i,
   input  logic                           vin_hs_i,
   input  logic                           vin_de_i,
   input  logic [fader_pkg::PIX_W-1:0]    vin_data_i,
   input  logic [$clog2(HBLKS)-1:0]       ht_cur_i,
   input  logic [$clog2(VBLKS)-1:0]       vt_cur_i,
   input  logic                           blk_i,
   output logic                           vout_vs_o,
   output logic                           vout_hs_o,
   output logic                           vout_de_o,
   output logic [fader_pkg::PIX_W-1:0]    vout_data_o,
   output logic                           dl_en_o,
   output logic                           ld_en_o,
   output logic                           dl_wipe_o,
   output logic                           ld_wipe_o
);

   localparam int PHASE     = (HBLKS + VBLKS / 2) * 256;
   localparam int PH_W      = $clog2(PHASE);
   localparam int REL_W     = PH_W;
   localparam int FW        = fader_pkg::FAN_W;
   localparam int FRAC_W    = fader_pkg::PHX_W - FW;
   localparam int FAN_WIDTH = 2 ** FW / 2;
   localparam int CW        = fader_pkg::COMP_W;
   localparam logic signed [REL_W-1:0] REL_MAX = {1'b0, {(REL_W - 1){1'b1}}};

   logic [PH_W-1:0]                 dl_phase, ld_phase, dl_phase_r, ld_phase_r;
   logic signed [REL_W-1:0]         dl_rel, ld_rel;
   logic [fader_pkg::PHX_W-1:0]     dl_phx, ld_phx, phx;
   logic                            blk_r, blk_rr;
   logic                            l_inv, d_inv;
   logic [CW-1:0]                   l_ctrl, d_ctrl, odd;
   logic [3:0]                      vs_d, hs_d, de_d;
   logic [fader_pkg::PIX_W-1:0]     data_d [3];

   // block distance behind the chevron front, in whole blocks
   function automatic logic signed [REL_W-1:0] front_rel(input int h, input int v,
                                                         input logic [PH_W-1:0] ph);
      int d;
      if (v < VBLKS / 2) begin
         d = int'(ph >> 8) + h + v - VBLKS / 2;
      end else begin
         d = int'(ph >> 8) + h - v + VBLKS / 2 - 1;
      end
      return REL_W'(d);
   endfunction

   function automatic logic [fader_pkg::PHX_W-1:0] front_phx(
      input logic signed [REL_W-1:0] rel, input logic [FRAC_W-1:0] frac);
      if (rel >= FAN_WIDTH) begin
         return '1; // new mapping
      end else if (rel < -FAN_WIDTH) begin
         return '0; // old mapping
      end
      return {FW'(rel + FAN_WIDTH), frac};
   endfunction

   // clamp and invert one component, light or dark half chosen by level
   function automatic logic [CW-1:0] remap(input logic [CW-1:0] c, input logic li,
                                           input logic di, input logic [CW-1:0] lc,
                                           input logic [CW-1:0] dc);
      logic [CW-1:0] r;
      if (c >= 127) begin
         r = c ^ {CW{li}};
         if ((!li && c > lc) || (li && ~c < lc)) r = lc;
      end else begin
         r = c ^ {CW{di}};
         if ((!di && c < dc) || (di && ~c > dc)) r = dc;
      end
      return r;
   endfunction

   fade_sequencer #(
      .SW_DELAY  (SW_DELAY),
      .PHASE     (PHASE),
      .PHASE_DIV (PHASE_DIV)
   ) u_dark_seq (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (dl_i),
      .en_o    (dl_en_o),
      .wipe_o  (dl_wipe_o),
      .phase_o (dl_phase)
   );

   fade_sequencer #(
      .SW_DELAY  (SW_DELAY),
      .PHASE     (PHASE),
      .PHASE_DIV (PHASE_DIV)
   ) u_light_seq (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (ld_i),
      .en_o    (ld_en_o),
      .wipe_o  (ld_wipe_o),
      .phase_o (ld_phase)
   );

   // stages 1 and 2: front distance, then blend phase
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         dl_rel <= REL_MAX;
         ld_rel <= REL_MAX;
         dl_phx <= '1;
         ld_phx <= '1;
      end else begin
         dl_rel <= dl_wipe_o ? front_rel(int'(ht_cur_i), int'(vt_cur_i), dl_phase) : REL_MAX;
         ld_rel <= ld_wipe_o ? front_rel(HBLKS - 1 - int'(ht_cur_i), int'(vt_cur_i), ld_phase)
                             : REL_MAX; // light wipe mirrored
         dl_phx <= front_phx(dl_rel, dl_phase_r[7 -: FRAC_W]);
         ld_phx <= front_phx(ld_rel, ld_phase_r[7 -: FRAC_W]);
      end
   end

   always_ff @(posedge clk_i) begin
      dl_phase_r <= dl_phase;
      ld_phase_r <= ld_phase;
      blk_r      <= blk_i;
      blk_rr     <= blk_r;
   end

   assign phx = blk_rr ? ld_phx : dl_phx;
   assign odd = {phx[6:0], 1'b1}; // (phx mod 128) * 2 + 1

   // stage 3: invert flags and clamp levels, phx[6] splits each half
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         {l_inv, d_inv} <= 2'b00;
         l_ctrl <= '1;
         d_ctrl <= '0;
      end else begin
         case ({blk_rr, blk_rr ? ld_en_o : dl_en_o, phx[7]})
            3'b010: {l_inv, d_inv, l_ctrl, d_ctrl} <= {phx[6], 1'b0, ~{phx[6:0], 1'b0}, 8'h00};
            3'b011: {l_inv, d_inv, l_ctrl, d_ctrl} <= {1'b1, phx[6], 8'h00, odd};
            3'b000: {l_inv, d_inv, l_ctrl, d_ctrl} <= {~phx[6], 1'b0, odd, 8'h00};
            3'b001: {l_inv, d_inv, l_ctrl, d_ctrl} <= {1'b0, ~phx[6], 8'hff, ~odd};
            3'b110: {l_inv, d_inv, l_ctrl, d_ctrl} <= {1'b0, ~phx[6], 8'h00, ~odd};
            3'b111: {l_inv, d_inv, l_ctrl, d_ctrl} <= {~phx[6], 1'b0, odd, 8'h00};
            3'b100: {l_inv, d_inv, l_ctrl, d_ctrl} <= {1'b0, phx[6], 8'hff, odd};
            default: {l_inv, d_inv, l_ctrl, d_ctrl} <= {phx[6], 1'b1, ~odd, 8'hff};
         endcase
      end
   end

   // timing and data pipeline, stage 4 is the remap register
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         vs_d        <= '0;
         hs_d        <= '0;
         de_d        <= '0;
         vout_data_o <= '0;
      end else begin
         vs_d <= {vs_d[2:0], vin_vs_i};
         hs_d <= {hs_d[2:0], vin_hs_i};
         de_d <= {de_d[2:0], vin_de_i};
         for (int i = 0; i < fader_pkg::PIX_W / CW; i++) begin
            vout_data_o[i*CW +: CW] <= remap(data_d[2][i*CW +: CW], l_inv, d_inv,
                                             l_ctrl, d_ctrl);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      data_d[0] <= vin_data_i;
      data_d[1] <= data_d[0];
      data_d[2] <= data_d[1];
   end

   assign vout_vs_o = vs_d[3];
   assign vout_hs_o = hs_d[3];
   assign vout_de_o = de_d[3];

endmodule

// ==== src/video_fader_top.sv ====
module video_fader_top #(
   parameter int HBLKS     = 10,
   parameter int VBLKS     = 10,
   parameter int BLK_W     = 64,
   parameter int BLK_H     = 64,
   parameter int SW_DELAY  = 16,
   parameter int PHASE_DIV = 1
) (
   input  logic                              clk_i,
   input  logic                              rst_ni,
   input  logic [fader_pkg::AXI_AW-1:0]      awaddr_i,
   input  logic                              awvalid_i,
   output logic                              awready_o,
   input  logic [fader_pkg::AXI_DW-1:0]      wdata_i,
   input  logic [fader_pkg::AXI_DW/8-1:0]    wstrb_i,
   input  logic                              wvalid_i,
   output logic                              wready_o,
   output logic [1:0]                        bresp_o,
   output logic                              bvalid_o,
   input  logic                              bready_i,
   input  logic [fader_pkg::AXI_AW-1:0]      araddr_i,
   input  logic                              arvalid_i,
   output logic                              arready_o,
   output logic [fader_pkg::AXI_DW-1:0]      rdata_o,
   output logic [1:0]                        rresp_o,
   output logic                              rvalid_o,
   input  logic                              rready_i,
   input  logic                              vin_vs_i,
   input  logic                              vin_hs_i,
   input  logic                              vin_de_i,
   input  logic [fader_pkg::PIX_W-1:0]       vin_data_i,
   output logic                              vout_vs_o,
   output logic                              vout_hs_o,
   output logic                              vout_de_o,
   output logic [fader_pkg::PIX_W-1:0]       vout_data_o
);

   logic                          dark_req, light_req, pat_inv;
   logic                          dl_en, ld_en, dl_wipe, ld_wipe;
   logic [3:0]                    status;
   logic                          loc_vs, loc_hs, loc_de, loc_blk;
   logic [fader_pkg::PIX_W-1:0]   loc_data;
   logic [$clog2(HBLKS)-1:0]      ht_cur;
   logic [$clog2(VBLKS)-1:0]      vt_cur;

   assign status[fader_pkg::ST_DARK_EN]    = dl_en;
   assign status[fader_pkg::ST_LIGHT_EN]   = ld_en;
   assign status[fader_pkg::ST_DARK_WIPE]  = dl_wipe;
   assign status[fader_pkg::ST_LIGHT_WIPE] = ld_wipe;

   axil_regs u_regs (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .awaddr_i    (awaddr_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .bresp_o     (bresp_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .araddr_i    (araddr_i),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .status_i    (status),
      .dark_req_o  (dark_req),
      .light_req_o (light_req),
      .pat_inv_o   (pat_inv)
   );

   block_locator #(
      .HBLKS (HBLKS),
      .VBLKS (VBLKS),
      .BLK_W (BLK_W),
      .BLK_H (BLK_H)
   ) u_locator (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .vin_vs_i   (vin_vs_i),
      .vin_hs_i   (vin_hs_i),
      .vin_de_i   (vin_de_i),
      .vin_data_i (vin_data_i),
      .pat_inv_i  (pat_inv),
      .vs_o       (loc_vs),
      .hs_o       (loc_hs),
      .de_o       (loc_de),
      .data_o     (loc_data),
      .ht_cur_o   (ht_cur),
      .vt_cur_o   (vt_cur),
      .blk_o      (loc_blk)
   );

   smoother #(
      .HBLKS     (HBLKS),
      .VBLKS     (VBLKS),
      .SW_DELAY  (SW_DELAY),
      .PHASE_DIV (PHASE_DIV)
   ) u_smoother (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .dl_i        (dark_req),
      .ld_i        (light_req),
      .vin_vs_i    (loc_vs),
      .vin_hs_i    (loc_hs),
      .vin_de_i    (loc_de),
      .vin_data_i  (loc_data),
      .ht_cur_i    (ht_cur),
      .vt_cur_i    (vt_cur),
      .blk_i       (loc_blk),
      .vout_vs_o   (vout_vs_o),
      .vout_hs_o   (vout_hs_o),
      .vout_de_o   (vout_de_o),
      .vout_data_o (vout_data_o),
      .dl_en_o     (dl_en),
      .ld_en_o     (ld_en),
      .dl_wipe_o   (dl_wipe),
      .ld_wipe_o   (ld_wipe)
   );

endmodule

// ==== tests/tb_video_fader.sv ====
module tb_video_fader;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HBLKS       = 4;
   localparam int VBLKS       = 4;
   localparam int BLK_W       = 4;
   localparam int BLK_H       = 2;
   localparam int SW_DELAY    = 16;
   localparam int PHASE_DIV   = 1;
   localparam int LAT         = 5; // locator 1 plus smoother 4
   localparam int LINE_PIX    = HBLKS * BLK_W;
   localparam int FRAME_LINES = VBLKS * BLK_H;
   localparam int FRAME_LEN   = 2 + FRAME_LINES * (LINE_PIX + 7) + 6;
   localparam int WIPE_LEN    = 256 * (HBLKS + VBLKS / 2) * PHASE_DIV;
   localparam int WIPE_MARGIN = 64;
   localparam int WAIT_MAX    = SW_DELAY + WIPE_LEN + 200;
   localparam int AXI_TMO     = 20;
   localparam int RUN_MAX     = 60000;

   logic                          clk, rst_n;
   logic [fader_pkg::AXI_AW-1:0]  awaddr, araddr;
   logic [fader_pkg::AXI_DW-1:0]  wdata, rdata;
   logic [fader_pkg::AXI_DW/8-1:0] wstrb;
   logic                          awvalid, awready, wvalid, wready, bvalid, bready;
   logic                          arvalid, arready, rvalid, rready;
   logic [1:0]                    bresp, rresp;
   logic                          vin_vs, vin_hs, vin_de, vout_vs, vout_hs, vout_de;
   logic [fader_pkg::PIX_W-1:0]   vin_data, vout_data;

   logic        want_dark, want_light, want_pat, check_en; // set by the test sequence
   logic        frame_dark, frame_light, frame_pat, frame_chk; // latched per frame
   logic [27:0] exp_q[$]; // {check, vs, hs, de, pixel}
   int          frame_cnt = 0;
   int          cyc = 0;
   int          checks = 0;
   int          errors = 0;
   int          seed = 32'h51afa21b;

   video_fader_top #(
      .HBLKS     (HBLKS),
      .VBLKS     (VBLKS),
      .BLK_W     (BLK_W),
      .BLK_H     (BLK_H),
      .SW_DELAY  (SW_DELAY),
      .PHASE_DIV (PHASE_DIV)
   ) uut (
      .clk_i       (clk),
      .rst_ni      (rst_n),
      .awaddr_i    (awaddr),
      .awvalid_i   (awvalid),
      .awready_o   (awready),
      .wdata_i     (wdata),
      .wstrb_i     (wstrb),
      .wvalid_i    (wvalid),
      .wready_o    (wready),
      .bresp_o     (bresp),
      .bvalid_o    (bvalid),
      .bready_i    (bready),
      .araddr_i    (araddr),
      .arvalid_i   (arvalid),
      .arready_o   (arready),
      .rdata_o     (rdata),
      .rresp_o     (rresp),
      .rvalid_o    (rvalid),
      .rready_i    (rready),
      .vin_vs_i    (vin_vs),
      .vin_hs_i    (vin_hs),
      .vin_de_i    (vin_de),
      .vin_data_i  (vin_data),
      .vout_vs_o   (vout_vs),
      .vout_hs_o   (vout_hs),
      .vout_de_o   (vout_de),
      .vout_data_o (vout_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc++;

   // steady state: dark blocks follow dark mode, light blocks follow light mode
   function automatic logic [fader_pkg::PIX_W-1:0] expected_pixel(
      input logic [fader_pkg::PIX_W-1:0] pix, input logic light,
      input logic dark_on, input logic light_on);
      logic inv;
      inv = (!light && dark_on) || (light && !light_on);
      return inv ? ~pix : pix;
   endfunction

   task automatic check_pixel(input logic [fader_pkg::PIX_W-1:0] got,
                              input logic [fader_pkg::PIX_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] vout_data_o got %h expected %h", got, exp);
      end
   endtask

   task automatic check_sync(input logic [2:0] got, input logic [2:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] {vout_vs_o, vout_hs_o, vout_de_o} got %h expected %h", got, exp);
      end
   endtask

   task automatic check_reg(input string name, input logic [fader_pkg::AXI_DW-1:0] got,
                            input logic [fader_pkg::AXI_DW-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] rdata_o (%s) got %h expected %h", name, got, exp);
      end
   endtask

   // one video clock, expected output queued alongside
   task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                              input logic [fader_pkg::PIX_W-1:0] pix, input logic light);
      logic [fader_pkg::PIX_W-1:0] want;
      @(negedge clk);
      vin_vs = vs;
      vin_hs = hs;
      vin_de = de;
      vin_data = pix;
      want = expected_pixel(pix, light, frame_dark, frame_light);
      exp_q.push_back({frame_chk & de, vs, hs, de, want});
   endtask

   task automatic blank_cycles(input int n, input logic vs, input logic hs);
      repeat (n) drive_cycle(vs, hs, 1'b0, '0, 1'b0);
   endtask

   task automatic axi_write(input logic [fader_pkg::AXI_AW-1:0] addr,
                            input logic [fader_pkg::AXI_DW-1:0] data);
      int n;
      @(negedge clk);
      awaddr = addr;
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      #1;
      checks++;
      if ({awready, wready} !== 2'b11) begin
         errors++;
         $display("[FAIL] {awready_o, wready_o} got %h expected %h", {awready, wready},
                  2'b11);
      end
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!bvalid && n < AXI_TMO);
      if (!bvalid) begin
         errors++;
         $display("write to address %h got no response", addr);
      end else if (bresp !== 2'b00) begin
         errors++;
         $display("[FAIL] bresp_o got %h expected %h", bresp, 2'b00);
      end
      awvalid = 1'b0;
      wvalid = 1'b0;
   endtask

   task automatic axi_read(input logic [fader_pkg::AXI_AW-1:0] addr,
                           output logic [fader_pkg::AXI_DW-1:0] data);
      int n;
      @(negedge clk);
      araddr = addr;
      arvalid = 1'b1;
      #1;
      checks++;
      if (arready !== 1'b1) begin
         errors++;
         $display("[FAIL] arready_o got %h expected %h", arready, 1'b1);
      end
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!rvalid && n < AXI_TMO);
      data = rdata;
      if (!rvalid) begin
         errors++;
         $display("read from address %h got no data", addr);
      end else if (rresp !== 2'b00) begin
         errors++;
         $display("[FAIL] rresp_o got %h expected %h", rresp, 2'b00);
      end
      arvalid = 1'b0;
   endtask

   task automatic wait_frames(input int n);
      int start;
      int t0;
      start = frame_cnt;
      t0 = cyc;
      while (frame_cnt < start + n && cyc - t0 < n * FRAME_LEN + 50) @(negedge clk);
      if (frame_cnt < start + n) begin
         errors++;
         $display("timeout while waiting for a new video frame");
      end
   endtask

   task automatic wait_status(input logic [3:0] want);
      logic [fader_pkg::AXI_DW-1:0] v;
      logic found;
      int t0;
      found = 1'b0;
      t0 = cyc;
      while (!found && cyc - t0 < WAIT_MAX) begin
         axi_read(fader_pkg::REG_STATUS, v);
         found = (v[3:0] == want);
      end
      if (!found) begin
         errors++;
         $display("timeout while waiting for STATUS to read %h", want);
      end
   endtask

   // pixel checks pause from a frame boundary until the wipe is over
   task automatic switch_mode(input logic [1:0] ctrl, input logic [3:0] wipe_st,
                              input logic [3:0] done_st);
      int t0;
      check_en = 1'b0;
      wait_frames(1);
      axi_write(fader_pkg::REG_CTRL, 32'(ctrl));
      t0 = cyc;
      wait_status(wipe_st);
      wait_status(done_st);
      if (cyc - t0 > SW_DELAY + WIPE_LEN + WIPE_MARGIN) begin
         errors++;
         $display("wipe ended %0d cycles after the write, limit %0d", cyc - t0,
                  SW_DELAY + WIPE_LEN + WIPE_MARGIN);
      end
      want_dark = ctrl[fader_pkg::CTRL_DARK];
      want_light = ctrl[fader_pkg::CTRL_LIGHT];
      check_en = 1'b1;
      wait_frames(2);
   endtask

   initial begin : video_gen
      logic [fader_pkg::PIX_W-1:0] pix;
      logic light;
      blank_cycles(2, 1'b0, 1'b0); // idle while reset is held
      forever begin
         frame_dark = want_dark;
         frame_light = want_light;
         frame_pat = want_pat;
         frame_chk = check_en;
         frame_cnt++;
         blank_cycles(2, 1'b1, 1'b0);
         for (int y = 0; y < FRAME_LINES; y++) begin
            blank_cycles(2, 1'b0, 1'b1);
            blank_cycles(2, 1'b0, 1'b0);
            for (int x = 0; x < LINE_PIX; x++) begin
               pix = 24'($random(seed));
               light = (((x / BLK_W) % 2) != ((y / BLK_H) % 2)) ^ frame_pat;
               drive_cycle(1'b0, 1'b0, 1'b1, pix, light);
            end
            blank_cycles(3, 1'b0, 1'b0);
         end
         blank_cycles(6, 1'b0, 1'b0);
      end
   end

   initial begin : compare_out
      logic [27:0] e;
      repeat (LAT) exp_q.push_back('0); // pipeline fill
      forever begin
         @(negedge clk);
         e = exp_q.pop_front();
         check_sync({vout_vs, vout_hs, vout_de}, e[26:24]);
         if (e[27]) begin
            check_pixel(vout_data, e[23:0]);
         end
      end
   end

   initial begin : watchdog
      repeat (RUN_MAX) @(posedge clk);
      $display("simulation ran out of time, checks %0d errors %0d", checks, errors);
      $display("Regression failed");
      $finish;
   end

   initial begin : run_test
      logic [fader_pkg::AXI_DW-1:0] rd;
      rst_n = 1'b0;
      {awaddr, araddr, wdata} = '0;
      wstrb = '1;
      {awvalid, wvalid, arvalid} = '0;
      bready = 1'b1;
      rready = 1'b1;
      {vin_vs, vin_hs, vin_de} = '0;
      vin_data = '0;
      {want_dark, want_light, want_pat} = '0;
      check_en = 1'b1;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      wait_frames(2); // idle mapping right after reset

      check_en = 1'b0;
      wait_frames(1);
      axi_write(fader_pkg::REG_PATTERN, 32'h1);
      axi_read(fader_pkg::REG_PATTERN, rd);
      check_reg("PATTERN", rd, 32'h1);
      axi_write(fader_pkg::REG_PATTERN, 32'h0);
      axi_read(fader_pkg::REG_PATTERN, rd);
      check_reg("PATTERN", rd, 32'h0);
      axi_write(fader_pkg::REG_CTRL, 32'h3);
      axi_read(fader_pkg::REG_CTRL, rd);
      check_reg("CTRL", rd, 32'h3);
      axi_write(fader_pkg::REG_CTRL, 32'h0); // back before the switch delay runs out
      axi_read(fader_pkg::REG_STATUS, rd);
      check_reg("STATUS", rd, 32'h0);
      axi_read(4'hc, rd);
      check_reg("unmapped", rd, 32'h0);
      check_en = 1'b1;
      wait_frames(2);

      switch_mode(2'b01, 4'h5, 4'h1); // dark on
      switch_mode(2'b11, 4'hb, 4'h3); // light on

      check_en = 1'b0;
      wait_frames(1);
      axi_write(fader_pkg::REG_PATTERN, 32'h1);
      want_pat = 1'b1;
      check_en = 1'b1;
      wait_frames(2);

      axi_write(fader_pkg::REG_CTRL, 32'h1); // short light-off glitch
      axi_write(fader_pkg::REG_CTRL, 32'h3);
      repeat (3 * SW_DELAY) @(negedge clk);
      axi_read(fader_pkg::REG_STATUS, rd);
      check_reg("STATUS", rd, 32'h3);
      wait_frames(2);

      switch_mode(2'b10, 4'h6, 4'h2); // dark off, timing checked through the wipe

      repeat (LAT + 2) @(negedge clk);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== tests/video_fader_checker.sv ====
module video_fader_checker (
   input logic                          clk_i,
   input logic                          rst_ni,
   input logic                          dl_en_i,
   input logic                          ld_en_i,
   input logic                          dl_wipe_i,
   input logic                          ld_wipe_i,
   input logic                          vin_de_i,
   input logic                          vout_de_i,
   input logic [fader_pkg::PIX_W-1:0]   vout_data_i
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [3:0] de_hist;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         de_hist <= '0;
      end else begin
         de_hist <= {de_hist[2:0], vin_de_i}; // de seen over the last 4 clocks
      end
   end

   reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |-> !(dl_en_i || ld_en_i || dl_wipe_i || ld_wipe_i) && vout_data_i == '0)
      else $error("smoother control or pixel output not cleared in reset");

   dark_wipe_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(dl_wipe_i) |-> $changed(dl_en_i))
      else $error("dark wipe started without a change of dark enable");

   light_wipe_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ld_wipe_i) |-> $changed(ld_en_i))
      else $error("light wipe started without a change of light enable");

   de_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vout_de_i == de_hist[3])
      else $error("vout_de_o does not follow vin_de_i by four clocks");

endmodule

bind smoother video_fader_checker u_checker (
   .clk_i       (clk_i),
   .rst_ni      (rst_ni),
   .dl_en_i     (dl_en_o),
   .ld_en_i     (ld_en_o),
   .dl_wipe_i   (dl_wipe_o),
   .ld_wipe_i   (ld_wipe_o),
   .vin_de_i    (vin_de_i),
   .vout_de_i   (vout_de_o),
   .vout_data_i (vout_data_o)
);
